//--- dv/tb_fb_fade_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_fb_fade_top
  import fb_pkg::*;
();

  localparam int PIXELS           = H_VISIBLE * V_VISIBLE;
  localparam int PLOT_WAIT_MAX    = 32;
  localparam int FRAME_CYCLES_MAX = H_TOTAL * V_TOTAL * 2;
  localparam int WATCHDOG_CYCLES  = 10 * FRAME_CYCLES_MAX + 1000;
  localparam int BURST_LEN        = 24;
  localparam int FADE_FRAMES      = 6;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic [X_BITS-1:0]     gfx_x;
  logic [Y_BITS-1:0]     gfx_y;
  logic [PIXEL_BITS-1:0] gfx_color;
  logic                  gfx_valid;
  logic                  gfx_ready;
  logic                  pixel_valid;
  logic                  hsync;
  logic                  vsync;
  logic                  visible;
  logic [COLOR_BITS-1:0] red;
  logic [COLOR_BITS-1:0] grn;
  logic [COLOR_BITS-1:0] blu;

  // expected frame contents, with ages
  int                    model_age [PIXELS] = '{default: 0};
  logic [PIXEL_BITS-1:0] model_rgb [PIXELS] = '{default: '0};

  // raster position of the next pixel_valid strobe
  int   h_pos = 0;
  int   v_pos = 0;
  int   frame_cnt = 0;
  int   line_strobes = 0;
  int   frame_lines = 0;
  int   frame_visible = 0;
  logic hs_seen = 1'b0;
  logic vs_seen = 1'b0;
  logic prev_hs = 1'b0;
  logic prev_vs = 1'b0;

  logic                  fade_track = 1'b0;
  int                    fade_addr = 0;
  logic [PIXEL_BITS-1:0] fade_seen [$];

  logic [16:0] lfsr_state = 17'd81565;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  fb_fade_top fb_fade_top_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .gfx_x       (gfx_x),
    .gfx_y       (gfx_y),
    .gfx_color   (gfx_color),
    .gfx_valid   (gfx_valid),
    .gfx_ready   (gfx_ready),
    .pixel_valid (pixel_valid),
    .hsync       (hsync),
    .vsync       (vsync),
    .visible     (visible),
    .red         (red),
    .grn         (grn),
    .blu         (blu)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  // x^17 + x^14 + 1
  function automatic logic [16:0] lfsr_step(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
  endfunction

  function automatic logic [15:0] take_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[14:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic value_error(input string name, input int got, input int expected);
    $display("ERROR at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, expected);
    errors++;
  endtask

  task automatic finish_test(input string name, input int first_err);
    tests_run++;
    if (errors != first_err) tests_failed++;
    $display("test %s: %0d errors", name, errors - first_err);
  endtask

  // one frame of display makes a lit pixel one step older
  function automatic void age_pixel(input int a);
    logic [COLOR_BITS-1:0] r;
    logic [COLOR_BITS-1:0] g;
    logic [COLOR_BITS-1:0] b;
    {r, g, b} = model_rgb[a];
    model_age[a] = model_age[a] - 1;
    if (model_age[a] == 0) begin
      model_rgb[a] = '0;
    end else if (model_age[a] == FADE_HALVE_AGE) begin
      model_rgb[a] = {r >> 1, g >> 1, b >> 1};
    end
  endfunction

  // rows whose reads or write-backs may be in flight right now
  function automatic logic row_is_busy(input int row);
    return (row == v_pos) || (row == (v_pos + 1) % V_TOTAL) ||
           (row == (v_pos + V_TOTAL - 1) % V_TOTAL);
  endfunction

  task automatic check_quiet();
    assert (!pixel_valid) else value_error("pixel_valid", int'(pixel_valid), 0);
    assert (!hsync) else value_error("hsync", int'(hsync), 0);
    assert (!vsync) else value_error("vsync", int'(vsync), 0);
    assert (!visible) else value_error("visible", int'(visible), 0);
    assert (!gfx_ready) else value_error("gfx_ready", int'(gfx_ready), 0);
  endtask

  // offer one plot and hold it until the writer takes it
  task automatic plot(input logic [X_BITS-1:0] x, input logic [Y_BITS-1:0] y,
                      input logic [PIXEL_BITS-1:0] color, input logic keep_valid);
    int waited;
    gfx_x     = x;
    gfx_y     = y;
    gfx_color = color;
    gfx_valid = 1'b1;
    waited    = 0;
    @(posedge clk);
    while (!gfx_ready && waited < PLOT_WAIT_MAX) begin
      waited++;
      @(posedge clk);
    end
    if (!gfx_ready) begin
      $display("plot at x=%0d y=%0d not accepted within %0d cycles", x, y, PLOT_WAIT_MAX);
      errors++;
    end
    @(negedge clk);
    if (!keep_valid) gfx_valid = 1'b0;
  endtask

  a_ready_idle: assert property (@(posedge clk) !gfx_valid |-> !gfx_ready)
    else value_error("gfx_ready", int'($sampled(gfx_ready)), 0);

  always @(posedge clk) begin : scoreboard
    logic                  exp_vis;
    logic                  exp_hs;
    logic                  exp_vs;
    logic [PIXEL_BITS-1:0] exp_rgb;
    int                    addr;
    if (rst_n && gfx_valid && gfx_ready) begin
      addr = int'(gfx_y) * H_VISIBLE + int'(gfx_x);
      model_age[addr] = NEW_AGE;
      model_rgb[addr] = gfx_color;
    end
    if (rst_n && pixel_valid) begin
      exp_vis = (h_pos < H_VISIBLE) && (v_pos < V_VISIBLE);
      exp_hs  = (h_pos >= H_VISIBLE + H_FRONT) && (h_pos < H_VISIBLE + H_FRONT + H_SYNC);
      exp_vs  = (v_pos >= V_VISIBLE + V_FRONT) && (v_pos < V_VISIBLE + V_FRONT + V_SYNC);
      addr    = v_pos * H_VISIBLE + h_pos;
      exp_rgb = '0;
      if (exp_vis) exp_rgb = model_rgb[addr];
      assert (visible == exp_vis) else value_error("visible", int'(visible), int'(exp_vis));
      assert (hsync == exp_hs) else value_error("hsync", int'(hsync), int'(exp_hs));
      assert (vsync == exp_vs) else value_error("vsync", int'(vsync), int'(exp_vs));
      assert ({red, grn, blu} == exp_rgb)
        else value_error($sformatf("rgb at (%0d,%0d)", h_pos, v_pos),
                         int'({red, grn, blu}), int'(exp_rgb));
      if (exp_vis && model_age[addr] != 0) age_pixel(addr);
      if (fade_track && exp_vis && addr == fade_addr) fade_seen.push_back({red, grn, blu});
      if (vsync && !prev_vs) begin
        if (vs_seen) assert (frame_lines == V_TOTAL)
          else value_error("lines per frame", frame_lines, V_TOTAL);
        vs_seen     = 1'b1;
        frame_lines = 0;
      end
      if (hsync && !prev_hs) begin
        if (hs_seen) assert (line_strobes == H_TOTAL)
          else value_error("strobes per line", line_strobes, H_TOTAL);
        hs_seen      = 1'b1;
        line_strobes = 0;
        frame_lines++;
      end
      line_strobes++;
      prev_hs = hsync;
      prev_vs = vsync;
      if (visible) frame_visible++;
      h_pos++;
      if (h_pos == H_TOTAL) begin
        h_pos = 0;
        v_pos++;
        if (v_pos == V_TOTAL) begin
          v_pos = 0;
          assert (frame_visible == PIXELS)
            else value_error("visible pixels per frame", frame_visible, PIXELS);
          frame_visible = 0;
          frame_cnt++;
        end
      end
    end
  end

  initial begin
    int                    first_err;
    int                    k;
    logic [X_BITS-1:0]     x;
    logic [Y_BITS-1:0]     y;
    logic [PIXEL_BITS-1:0] c;
    logic [PIXEL_BITS-1:0] half;
    logic [PIXEL_BITS-1:0] exp_rgb;
    rst_n     = 1'b0;
    gfx_x     = '0;
    gfx_y     = '0;
    gfx_color = '0;
    gfx_valid = 1'b0;

    first_err = errors;
    repeat (8) begin
      @(negedge clk);
      check_quiet();
    end
    rst_n = 1'b1;
    @(negedge clk);
    check_quiet();
    finish_test("reset", first_err);

    // the scoreboard checks every strobe, two frames give two vsync periods
    first_err = errors;
    wait (frame_cnt >= 2);
    finish_test("raster", first_err);

    // plots in vsync, the last one is followed through its fade
    first_err = errors;
    wait (v_pos == V_VISIBLE + V_FRONT);
    @(negedge clk);
    k = frame_cnt;
    repeat (4) begin
      x = X_BITS'(take_bits(X_BITS));
      y = Y_BITS'(take_bits(Y_BITS));
      c = PIXEL_BITS'(take_bits(PIXEL_BITS));
      plot(x, y, c, 1'b0);
    end
    x = X_BITS'(take_bits(X_BITS));
    y = Y_BITS'(take_bits(Y_BITS));
    c = PIXEL_BITS'(take_bits(PIXEL_BITS)) | 12'h888;
    plot(x, y, c, 1'b0);
    fade_addr = int'(y) * H_VISIBLE + int'(x);
    fade_seen.delete();
    fade_track = 1'b1;
    wait (frame_cnt >= k + 2);
    finish_test("plot", first_err);

    first_err = errors;
    wait (frame_cnt >= k + 1 + FADE_FRAMES);
    fade_track = 1'b0;
    half = {c[11:8] >> 1, c[7:4] >> 1, c[3:0] >> 1};
    for (int i = 0; i < FADE_FRAMES; i++) begin
      exp_rgb = (i < 2) ? c : (i < 4) ? half : '0;
      assert (fade_seen[i] == exp_rgb)
        else value_error($sformatf("fade frame %0d", i + 1),
                         int'(fade_seen[i]), int'(exp_rgb));
    end
    finish_test("fade", first_err);

    // back-to-back plots while the scanout is busy on visible lines
    first_err = errors;
    @(negedge clk);
    for (int i = 0; i < BURST_LEN; i++) begin
      x = X_BITS'(take_bits(X_BITS));
      y = Y_BITS'(take_bits(Y_BITS));
      c = PIXEL_BITS'(take_bits(PIXEL_BITS));
      while (row_is_busy(int'(y))) y = y + 1'b1;
      plot(x, y, c, i < BURST_LEN - 1);
    end
    k = frame_cnt;
    wait (frame_cnt >= k + 2);
    finish_test("burst", first_err);

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // ten worst-case frames plus slack for reset and setup
  initial begin
    #(WATCHDOG_CYCLES * 10);
    $display("watchdog expired, run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
rtl/fb_pkg.sv
rtl/fb_port_if.sv
rtl/fb_memory.sv
rtl/fb_arbiter.sv
rtl/gfx_writer.sv
rtl/fb_scanout.sv
rtl/fade_unit.sv
rtl/fb_fade_top.sv
dv/tb_fb_fade_top.sv

//--- rtl/fade_unit.sv
`timescale 1ns/100ps
`default_nettype none

module fade_unit
  import fb_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 shown_valid,
  input  logic [ADDR_BITS-1:0] shown_addr,
  input  logic [WORD_BITS-1:0] shown_word,
  output logic                 fade_room,
  fb_port_if.requester         port
);

  logic [AGE_BITS-1:0]   age;
  logic [COLOR_BITS-1:0] r;
  logic [COLOR_BITS-1:0] g;
  logic [COLOR_BITS-1:0] b;
  logic [AGE_BITS-1:0]   next_age;
  logic [PIXEL_BITS-1:0] next_color;

  logic                 pipe_valid;
  logic [ADDR_BITS-1:0] pipe_addr;
  logic [WORD_BITS-1:0] pipe_word;

  logic [ADDR_BITS-1:0]                  q_addr [FADE_QUEUE_DEPTH];
  logic [WORD_BITS-1:0]                  q_word [FADE_QUEUE_DEPTH];
  logic [$clog2(FADE_QUEUE_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(FADE_QUEUE_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(FADE_QUEUE_DEPTH+1)-1:0] count;
  logic                                  push;
  logic                                  pop;

  assign {age, r, g, b} = shown_word;

  // one step older, dimmed at the halve age, dark once the age runs out
  always_comb begin
    next_age = (age != '0) ? age - 1'b1 : '0;
    if (next_age == '0) begin
      next_color = '0;
    end else if (next_age == FADE_HALVE_AGE) begin
      next_color = {r >> 1, g >> 1, b >> 1};
    end else begin
      next_color = {r, g, b};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pipe_valid <= 1'b0;
    end else begin
      pipe_valid <= shown_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (shown_valid) begin
      pipe_addr <= shown_addr;
      pipe_word <= {next_age, next_color};
    end
  end

  assign push = pipe_valid;
  assign pop  = port.gnt;

  always_ff @(posedge clk) begin
    if (push) begin
      q_addr[wr_ptr] <= pipe_addr;
      q_word[wr_ptr] <= pipe_word;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // the entry still in the pipeline counts as taken
  assign fade_room = (count + pipe_valid) <= FADE_QUEUE_DEPTH - 2;

  assign port.req   = (count != '0);
  assign port.we    = 1'b1;
  assign port.addr  = q_addr[rd_ptr];
  assign port.wdata = q_word[rd_ptr];

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> count != FADE_QUEUE_DEPTH);

endmodule

`default_nettype wire

//--- rtl/fb_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module fb_arbiter
  import fb_pkg::*;
(
  input logic           clk,
  input logic           rst_n,
  fb_port_if.arbiter    scan,
  fb_port_if.arbiter    fade,
  fb_port_if.arbiter    gfx,
  fb_port_if.requester  mem
);

  owner_t owner;
  owner_t last_writer;

  // scanout always first, the two writers take turns on a tie
  always_comb begin
    if (scan.req) begin
      owner = OWN_SCAN;
    end else if (fade.req && gfx.req) begin
      owner = (last_writer == OWN_FADE) ? OWN_GFX : OWN_FADE;
    end else if (fade.req) begin
      owner = OWN_FADE;
    end else if (gfx.req) begin
      owner = OWN_GFX;
    end else begin
      owner = OWN_NONE;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_writer <= OWN_GFX;
    end else if (owner == OWN_FADE || owner == OWN_GFX) begin
      last_writer <= owner;
    end
  end

  always_comb begin
    mem.req   = (owner != OWN_NONE);
    mem.we    = 1'b0;
    mem.addr  = '0;
    mem.wdata = '0;
    case (owner)
      OWN_SCAN: begin
        mem.we    = scan.we;
        mem.addr  = scan.addr;
        mem.wdata = scan.wdata;
      end
      OWN_FADE: begin
        mem.we    = fade.we;
        mem.addr  = fade.addr;
        mem.wdata = fade.wdata;
      end
      OWN_GFX: begin
        mem.we    = gfx.we;
        mem.addr  = gfx.addr;
        mem.wdata = gfx.wdata;
      end
      default: begin
        mem.we = 1'b0;
      end
    endcase
  end

  assign scan.gnt = (owner == OWN_SCAN);
  assign fade.gnt = (owner == OWN_FADE);
  assign gfx.gnt  = (owner == OWN_GFX);

  assign scan.rdata = mem.rdata;
  assign fade.rdata = mem.rdata;
  assign gfx.rdata  = mem.rdata;

  a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({scan.gnt, fade.gnt, gfx.gnt}));

  a_grant_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    (!scan.gnt || scan.req) && (!fade.gnt || fade.req) && (!gfx.gnt || gfx.req));

endmodule

`default_nettype wire

//--- rtl/fb_fade_top.sv
`timescale 1ns/100ps
`default_nettype none

module fb_fade_top
  import fb_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [X_BITS-1:0]     gfx_x,
  input  logic [Y_BITS-1:0]     gfx_y,
  input  logic [PIXEL_BITS-1:0] gfx_color,
  input  logic                  gfx_valid,
  output logic                  gfx_ready,
  output logic                  pixel_valid,
  output logic                  hsync,
  output logic                  vsync,
  output logic                  visible,
  output logic [COLOR_BITS-1:0] red,
  output logic [COLOR_BITS-1:0] grn,
  output logic [COLOR_BITS-1:0] blu
);

  fb_port_if scan_port ();
  fb_port_if fade_port ();
  fb_port_if gfx_port ();
  fb_port_if mem_port ();

  // scanout to fade unit
  logic                 shown_valid;
  logic [ADDR_BITS-1:0] shown_addr;
  logic [WORD_BITS-1:0] shown_word;
  logic                 fade_room;

  fb_memory fb_memory_i (
    .clk (clk),
    .mem (mem_port.memory)
  );

  fb_arbiter fb_arbiter_i (
    .clk   (clk),
    .rst_n (rst_n),
    .scan  (scan_port.arbiter),
    .fade  (fade_port.arbiter),
    .gfx   (gfx_port.arbiter),
    .mem   (mem_port.requester)
  );

  gfx_writer gfx_writer_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .gfx_x     (gfx_x),
    .gfx_y     (gfx_y),
    .gfx_color (gfx_color),
    .gfx_valid (gfx_valid),
    .gfx_ready (gfx_ready),
    .port      (gfx_port.requester)
  );

  fb_scanout fb_scanout_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .port        (scan_port.requester),
    .fade_room   (fade_room),
    .shown_valid (shown_valid),
    .shown_addr  (shown_addr),
    .shown_word  (shown_word),
    .pixel_valid (pixel_valid),
    .hsync       (hsync),
    .vsync       (vsync),
    .visible     (visible),
    .red         (red),
    .grn         (grn),
    .blu         (blu)
  );

  fade_unit fade_unit_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .shown_valid (shown_valid),
    .shown_addr  (shown_addr),
    .shown_word  (shown_word),
    .fade_room   (fade_room),
    .port        (fade_port.requester)
  );

endmodule

`default_nettype wire

//--- rtl/fb_memory.sv
`timescale 1ns/100ps
`default_nettype none

module fb_memory
  import fb_pkg::*;
(
  input logic        clk,
  fb_port_if.memory  mem
);

  // frame starts out blank
  logic [WORD_BITS-1:0] words [2**ADDR_BITS] = '{default: '0};

  // one port, so a write cycle leaves rdata holding the last read
  always_ff @(posedge clk) begin
    if (mem.req) begin
      if (mem.we) begin
        words[mem.addr] <= mem.wdata;
      end else begin
        mem.rdata <= words[mem.addr];
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/fb_pkg.sv
`default_nettype none

package fb_pkg;

  // horizontal raster, in pixels
  localparam int H_VISIBLE = 16;
  localparam int H_FRONT   = 2;
  localparam int H_SYNC    = 3;
  localparam int H_BACK    = 3;
  localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;

  // vertical raster, in lines
  localparam int V_VISIBLE = 8;
  localparam int V_FRONT   = 1;
  localparam int V_SYNC    = 2;
  localparam int V_BACK    = 1;
  localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

  localparam int X_BITS    = 4;
  localparam int Y_BITS    = 3;
  localparam int ADDR_BITS = 7;

  // stored word is {age, red, grn, blu}
  localparam int COLOR_BITS = 4;
  localparam int PIXEL_BITS = 3 * COLOR_BITS;
  localparam int AGE_BITS   = 4;
  localparam int WORD_BITS  = AGE_BITS + PIXEL_BITS;

  localparam int NEW_AGE          = 4;
  localparam int FADE_HALVE_AGE   = 2;
  localparam int FADE_QUEUE_DEPTH = 4;

  typedef enum logic {SCAN_ISSUE, SCAN_DATA} scan_state_t;

  typedef enum logic [1:0] {OWN_NONE, OWN_SCAN, OWN_FADE, OWN_GFX} owner_t;

endpackage

`default_nettype wire

//--- rtl/fb_port_if.sv
`timescale 1ns/100ps
`default_nettype none

interface fb_port_if import fb_pkg::*; ();

  logic                 req;
  logic                 we;
  logic [ADDR_BITS-1:0] addr;
  logic [WORD_BITS-1:0] wdata;
  logic                 gnt;
  logic [WORD_BITS-1:0] rdata;

  modport requester (output req, output we, output addr, output wdata,
                     input gnt, input rdata);

  // the arbiter hands the shared read data back to each requester
  modport arbiter (input req, input we, input addr, input wdata,
                   output gnt, output rdata);

  modport memory (input req, input we, input addr, input wdata, output rdata);

endinterface

`default_nettype wire

//--- rtl/fb_scanout.sv
`timescale 1ns/100ps
`default_nettype none

module fb_scanout
  import fb_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  fb_port_if.requester          port,
  input  logic                  fade_room,
  output logic                  shown_valid,
  output logic [ADDR_BITS-1:0]  shown_addr,
  output logic [WORD_BITS-1:0]  shown_word,
  output logic                  pixel_valid,
  output logic                  hsync,
  output logic                  vsync,
  output logic                  visible,
  output logic [COLOR_BITS-1:0] red,
  output logic [COLOR_BITS-1:0] grn,
  output logic [COLOR_BITS-1:0] blu
);

  logic [$clog2(H_TOTAL)-1:0] h_cnt;
  logic [$clog2(V_TOTAL)-1:0] v_cnt;
  scan_state_t                state;
  logic                       in_visible;
  logic                       in_hsync;
  logic                       in_vsync;
  logic                       emit;
  logic [ADDR_BITS-1:0]       pix_addr;

  assign in_visible = (h_cnt < H_VISIBLE) && (v_cnt < V_VISIBLE);
  assign in_hsync   = (h_cnt >= H_VISIBLE + H_FRONT) &&
                      (h_cnt < H_VISIBLE + H_FRONT + H_SYNC);
  assign in_vsync   = (v_cnt >= V_VISIBLE + V_FRONT) &&
                      (v_cnt < V_VISIBLE + V_FRONT + V_SYNC);
  assign pix_addr   = ADDR_BITS'(v_cnt * H_VISIBLE + h_cnt);

  // blanking goes out at once, visible pixels wait for their read data
  assign emit = (state == SCAN_DATA) || !in_visible;

  // hold off new reads while the fade queue could overflow
  assign port.req   = (state == SCAN_ISSUE) && in_visible && fade_room;
  assign port.we    = 1'b0;
  assign port.addr  = pix_addr;
  assign port.wdata = '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= SCAN_ISSUE;
      h_cnt <= '0;
      v_cnt <= '0;
    end else begin
      case (state)
        SCAN_ISSUE: if (port.gnt) state <= SCAN_DATA;
        SCAN_DATA:  state <= SCAN_ISSUE;
        default:    state <= SCAN_ISSUE;
      endcase
      if (emit) begin
        if (h_cnt == H_TOTAL - 1) begin
          h_cnt <= '0;
          v_cnt <= (v_cnt == V_TOTAL - 1) ? '0 : v_cnt + 1'b1;
        end else begin
          h_cnt <= h_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pixel_valid <= 1'b0;
      hsync       <= 1'b0;
      vsync       <= 1'b0;
      visible     <= 1'b0;
      shown_valid <= 1'b0;
    end else begin
      pixel_valid <= emit;
      shown_valid <= (state == SCAN_DATA) &&
                     (port.rdata[WORD_BITS-1 -: AGE_BITS] != '0);
      if (emit) begin
        hsync   <= in_hsync;
        vsync   <= in_vsync;
        visible <= in_visible;
      end
    end
  end

  // colour shown is the stored one, before any fading
  always_ff @(posedge clk) begin
    if (emit) begin
      {red, grn, blu} <= (state == SCAN_DATA) ? port.rdata[PIXEL_BITS-1:0] : '0;
    end
    if (state == SCAN_DATA) begin
      shown_addr <= pix_addr;
      shown_word <= port.rdata;
    end
  end

  // every granted read comes out as a visible pixel
  a_read_in_visible: assert property (@(posedge clk) disable iff (!rst_n)
    port.gnt |-> ##2 (pixel_valid && visible));

endmodule

`default_nettype wire

//--- rtl/gfx_writer.sv
`timescale 1ns/100ps
`default_nettype none

module gfx_writer
  import fb_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [X_BITS-1:0]     gfx_x,
  input  logic [Y_BITS-1:0]     gfx_y,
  input  logic [PIXEL_BITS-1:0] gfx_color,
  input  logic                  gfx_valid,
  output logic                  gfx_ready,
  fb_port_if.requester          port
);

  // row-major frame, one word per pixel
  assign port.addr  = ADDR_BITS'(gfx_y * H_VISIBLE + gfx_x);
  assign port.wdata = {AGE_BITS'(NEW_AGE), gfx_color};
  assign port.we    = 1'b1;
  assign port.req   = gfx_valid;

  // plot is taken on the cycle it wins the memory
  assign gfx_ready = port.gnt;

  a_plot_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
    gfx_valid |-> (gfx_x < H_VISIBLE) && (gfx_y < V_VISIBLE));

  // a waiting plot must not change under us
  a_plot_held: assert property (@(posedge clk) disable iff (!rst_n)
    gfx_valid && !gfx_ready |=> gfx_valid && $stable({gfx_x, gfx_y, gfx_color}));

endmodule

`default_nettype wire
